//--- source/pkt_pkg.sv
// Packet bus definitions
`default_nettype none

package pkt_pkg;

   // --------------------------------------------------
   // Word widths and port count
   // --------------------------------------------------
   localparam int data_width = 64;
   localparam int ctrl_width = 8;
   localparam int num_ports  = 4;

   typedef logic [$clog2(num_ports)-1:0] port_idx_t;
   typedef logic [num_ports-1:0]         port_mask_t;
   typedef logic [data_width-1:0]        pkt_data_t;
   typedef logic [ctrl_width-1:0]        pkt_ctrl_t;

   // Control word codes
   localparam pkt_ctrl_t ctrl_module_hdr = 8'hff;
   localparam pkt_ctrl_t ctrl_payload    = 8'h00;

   // --------------------------------------------------
   // Module header layout
   // --------------------------------------------------
   localparam int hdr_dst_lsb = 48;
   localparam int hdr_src_lsb = 16;

   // Words per output FIFO
   localparam int oq_depth = 16;

   // Any other nonzero control code ends a packet
   function automatic logic is_last_word(pkt_ctrl_t ctrl);
      return (ctrl != ctrl_module_hdr) && (ctrl != ctrl_payload);
   endfunction

endpackage

`default_nettype wire

//--- source/reg_pkg.sv
// Register ring definitions
`default_nettype none

package reg_pkg;

   localparam int reg_addr_width = 23;
   localparam int reg_data_width = 32;
   localparam int reg_src_width  = 2;

   typedef logic [reg_addr_width-1:0] reg_addr_t;
   typedef logic [reg_data_width-1:0] reg_data_t;
   typedef logic [reg_src_width-1:0]  reg_src_t;

   // --------------------------------------------------
   // Address map
   // --------------------------------------------------
   localparam int block_lsb = 16;

   typedef logic [reg_addr_width-block_lsb-1:0] reg_block_t;
   typedef logic [block_lsb-1:0]                reg_offset_t;

   localparam reg_block_t block_op_lut  = reg_block_t'(1);
   localparam reg_block_t block_oq      = reg_block_t'(2);
   localparam reg_data_t  reg_no_target = 32'hdead_beef;

   function automatic reg_block_t reg_block(reg_addr_t addr);
      return addr[reg_addr_width-1:block_lsb];
   endfunction

   function automatic reg_offset_t reg_offset(reg_addr_t addr);
      return addr[block_lsb-1:0];
   endfunction

endpackage

`default_nettype wire

//--- source/pkt_bus_if.sv
// Packet word link
`timescale 1ns/1ps
`default_nettype none

interface pkt_bus_if
   import pkt_pkg::*;
();

   pkt_data_t data;
   pkt_ctrl_t ctrl;
   logic      wr;
   // High when the receiver takes a word this cycle
   logic      rdy;

   modport src (output data, ctrl, wr, input rdy);
   modport dst (input data, ctrl, wr, output rdy);

endinterface

`default_nettype wire

//--- source/reg_ring_if.sv
// Register ring hop
`timescale 1ns/1ps
`default_nettype none

interface reg_ring_if
   import reg_pkg::*;
();

   // One-cycle request pulse
   logic      req;
   // Set by the stage that claims the access
   logic      ack;
   logic      rd_wr_l;
   reg_addr_t addr;
   reg_data_t data;
   reg_src_t  src;

   modport up (output req, ack, rd_wr_l, addr, data, src);
   modport down (input req, ack, rd_wr_l, addr, data, src);

endinterface

`default_nettype wire

//--- source/input_arbiter.sv
// Packet round-robin input arbiter
`timescale 1ns/1ps
`default_nettype none

module input_arbiter
   import pkt_pkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   input  pkt_data_t            in_data [num_ports],
   input  pkt_ctrl_t            in_ctrl [num_ports],
   input  logic [num_ports-1:0] in_wr,
   output logic [num_ports-1:0] in_rdy,
   pkt_bus_if.src               out,
   reg_ring_if.down             reg_in,
   reg_ring_if.up               reg_out
);

   port_idx_t cur_port;
   logic      in_pkt;
   logic      out_vld;
   logic      stall;
   logic      accept;
   pkt_data_t in_word;

   // --------------------------------------------------
   // Grant and output register
   // --------------------------------------------------
   assign stall  = out_vld && !out.rdy;
   assign accept = in_wr[cur_port] && !stall;
   assign out.wr = out_vld && out.rdy;

   // Only the granted port sees rdy
   always_comb
   begin
      in_rdy           = '0;
      in_rdy[cur_port] = !stall;
   end

   // Stamp the source port into the header
   always_comb
   begin
      in_word = in_data[cur_port];
      if (in_ctrl[cur_port] == ctrl_module_hdr)
         in_word[hdr_src_lsb +: $bits(port_idx_t)] = cur_port;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         cur_port <= '0;
         in_pkt   <= 1'b0;
         out_vld  <= 1'b0;
      end
      else
      begin
         if (!stall)
            out_vld <= accept;
         if (accept)
         begin
            in_pkt <= !is_last_word(in_ctrl[cur_port]);
            if (is_last_word(in_ctrl[cur_port]))
               cur_port <= cur_port + port_idx_t'(1);
         end
         else if (!in_pkt)
            cur_port <= cur_port + port_idx_t'(1);
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         out.data <= in_word;
         out.ctrl <= in_ctrl[cur_port];
      end
   end

   // --------------------------------------------------
   // Register ring hop, no registers here
   // --------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         reg_out.req <= 1'b0;
         reg_out.ack <= 1'b0;
      end
      else
      begin
         reg_out.req <= reg_in.req;
         reg_out.ack <= reg_in.ack;
      end
   end

   always_ff @(posedge clk)
   begin
      reg_out.rd_wr_l <= reg_in.rd_wr_l;
      reg_out.addr    <= reg_in.addr;
      reg_out.data    <= reg_in.data;
      reg_out.src     <= reg_in.src;
   end

   // A word written on a port that is not ready would be lost
   assert property (@(posedge clk) disable iff (reset) (in_wr & ~in_rdy) == '0);

endmodule

`default_nettype wire

//--- source/output_port_lookup.sv
// Output port lookup stage
`timescale 1ns/1ps
`default_nettype none

module output_port_lookup
   import pkt_pkg::*, reg_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   pkt_bus_if.dst   in,
   pkt_bus_if.src   out,
   reg_ring_if.down reg_in,
   reg_ring_if.up   reg_out
);

   port_mask_t lut [num_ports];
   logic       out_vld;
   port_idx_t  src_port;
   logic       reg_hit;
   port_idx_t  reg_idx;

   // --------------------------------------------------
   // Header rewrite
   // --------------------------------------------------
   assign in.rdy   = !out_vld || out.rdy;
   assign out.wr   = out_vld && out.rdy;
   assign src_port = in.data[hdr_src_lsb +: $bits(port_idx_t)];

   always_ff @(posedge clk)
   begin
      if (reset)
         out_vld <= 1'b0;
      else if (in.rdy)
         out_vld <= in.wr;
   end

   always_ff @(posedge clk)
   begin
      if (in.wr)
      begin
         out.data <= in.data;
         out.ctrl <= in.ctrl;
         if (in.ctrl == ctrl_module_hdr)
            out.data[hdr_dst_lsb +: num_ports] <= lut[src_port];
      end
   end

   // --------------------------------------------------
   // Lookup table registers
   // --------------------------------------------------
   assign reg_idx = port_idx_t'(reg_offset(reg_in.addr));
   assign reg_hit = reg_in.req && !reg_in.ack
                    && (reg_block(reg_in.addr) == block_op_lut)
                    && (reg_offset(reg_in.addr) < num_ports);

   // Default route sends port i to port i xor 1
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < num_ports; i++)
            lut[i] <= port_mask_t'(1) << (i ^ 1);
      end
      else if (reg_hit && !reg_in.rd_wr_l)
         lut[reg_idx] <= reg_in.data[num_ports-1:0];
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         reg_out.req <= 1'b0;
         reg_out.ack <= 1'b0;
      end
      else
      begin
         reg_out.req <= reg_in.req;
         reg_out.ack <= reg_in.ack || reg_hit;
      end
   end

   always_ff @(posedge clk)
   begin
      reg_out.rd_wr_l <= reg_in.rd_wr_l;
      reg_out.addr    <= reg_in.addr;
      reg_out.src     <= reg_in.src;
      if (reg_hit && reg_in.rd_wr_l)
         reg_out.data <= reg_data_t'(lut[reg_idx]);
      else
         reg_out.data <= reg_in.data;
   end

endmodule

`default_nettype wire

//--- source/output_queues.sv
// Multicast output queues
`timescale 1ns/1ps
`default_nettype none

module output_queues
   import pkt_pkg::*, reg_pkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   pkt_bus_if.dst               in,
   output pkt_data_t            out_data [num_ports],
   output pkt_ctrl_t            out_ctrl [num_ports],
   output logic [num_ports-1:0] out_wr,
   input  logic [num_ports-1:0] out_rdy,
   reg_ring_if.down             reg_in,
   reg_ring_if.up               reg_out
);

   typedef logic [$clog2(oq_depth)-1:0] ptr_t;
   typedef logic [$clog2(oq_depth):0]   cnt_t;

   port_mask_t           pkt_mask;
   port_mask_t           wr_mask;
   logic [num_ports-1:0] full;
   logic [num_ports-1:0] fifo_wr;
   reg_data_t            pkt_cnt [num_ports];
   logic                 reg_hit;
   port_idx_t            reg_idx;

   // --------------------------------------------------
   // Enqueue
   // --------------------------------------------------
   assign in.rdy  = ~|full;
   assign wr_mask = (in.ctrl == ctrl_module_hdr) ? in.data[hdr_dst_lsb +: num_ports]
                                                 : pkt_mask;
   assign fifo_wr = in.wr ? wr_mask : '0;

   // Mask holds for the rest of the packet
   always_ff @(posedge clk)
   begin
      if (reset)
         pkt_mask <= '0;
      else if (in.wr && (in.ctrl == ctrl_module_hdr))
         pkt_mask <= in.data[hdr_dst_lsb +: num_ports];
   end

   // --------------------------------------------------
   // Per-port FIFOs and packet counters
   // --------------------------------------------------
   for (genvar p = 0; p < num_ports; p++)
   begin : g_queue
      pkt_data_t data_mem [oq_depth];
      pkt_ctrl_t ctrl_mem [oq_depth];
      ptr_t      wr_ptr;
      ptr_t      rd_ptr;
      cnt_t      count;

      assign full[p]     = (count == cnt_t'(oq_depth));
      assign out_wr[p]   = (count != '0) && out_rdy[p];
      assign out_data[p] = data_mem[rd_ptr];
      assign out_ctrl[p] = ctrl_mem[rd_ptr];

      always_ff @(posedge clk)
      begin
         if (fifo_wr[p])
         begin
            data_mem[wr_ptr] <= in.data;
            ctrl_mem[wr_ptr] <= in.ctrl;
         end
      end

      always_ff @(posedge clk)
      begin
         if (reset)
         begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            pkt_cnt[p] <= '0;
         end
         else
         begin
            if (fifo_wr[p])
               wr_ptr <= wr_ptr + ptr_t'(1);
            if (out_wr[p])
               rd_ptr <= rd_ptr + ptr_t'(1);
            count <= count + cnt_t'(fifo_wr[p]) - cnt_t'(out_wr[p]);
            if (out_wr[p] && is_last_word(out_ctrl[p]))
               pkt_cnt[p] <= pkt_cnt[p] + reg_data_t'(1);
         end
      end

      // Lookup stage must hold off while any queue is full
      assert property (@(posedge clk) disable iff (reset) fifo_wr[p] |-> !full[p]);
   end

   // --------------------------------------------------
   // Counter registers
   // --------------------------------------------------
   assign reg_idx = port_idx_t'(reg_offset(reg_in.addr));
   assign reg_hit = reg_in.req && !reg_in.ack
                    && (reg_block(reg_in.addr) == block_oq)
                    && (reg_offset(reg_in.addr) < num_ports);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         reg_out.req <= 1'b0;
         reg_out.ack <= 1'b0;
      end
      else
      begin
         reg_out.req <= reg_in.req;
         reg_out.ack <= reg_in.ack || reg_hit;
      end
   end

   // Counters are read only, writes just get the ack
   always_ff @(posedge clk)
   begin
      reg_out.rd_wr_l <= reg_in.rd_wr_l;
      reg_out.addr    <= reg_in.addr;
      reg_out.src     <= reg_in.src;
      if (reg_hit && reg_in.rd_wr_l)
         reg_out.data <= pkt_cnt[reg_idx];
      else
         reg_out.data <= reg_in.data;
   end

endmodule

`default_nettype wire

//--- source/udp_reg_master.sv
// Register ring master
`timescale 1ns/1ps
`default_nettype none

module udp_reg_master
   import reg_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      reg_req,
   input  logic      reg_rd_wr_l,
   input  reg_addr_t reg_addr,
   input  reg_data_t reg_wr_data,
   output logic      reg_ack,
   output reg_data_t reg_rd_data,
   reg_ring_if.up    ring_out,
   reg_ring_if.down  ring_in
);

   logic pending;
   logic launch;

   // Core keeps reg_req up through the ack cycle
   assign launch       = reg_req && !pending && !reg_ack;
   assign ring_out.ack = 1'b0;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         pending      <= 1'b0;
         ring_out.req <= 1'b0;
         reg_ack      <= 1'b0;
      end
      else
      begin
         ring_out.req <= launch;
         reg_ack      <= ring_in.req;
         if (launch)
            pending <= 1'b1;
         else if (ring_in.req)
            pending <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (launch)
      begin
         ring_out.rd_wr_l <= reg_rd_wr_l;
         ring_out.addr    <= reg_addr;
         ring_out.data    <= reg_wr_data;
         ring_out.src     <= '0;
      end
      // Unclaimed access comes back with ack low
      if (ring_in.req)
         reg_rd_data <= ring_in.ack ? ring_in.data : reg_no_target;
   end

   // Every reply on the ring belongs to an access in flight
   assert property (@(posedge clk) disable iff (reset) ring_in.req |-> pending);

endmodule

`default_nettype wire

//--- source/user_data_path.sv
// User data path top level
`timescale 1ns/1ps
`default_nettype none

module user_data_path
   import pkt_pkg::*, reg_pkg::*;
(
   input  logic                 clk,
   input  logic                 reset,

   input  pkt_data_t            in_data  [num_ports],
   input  pkt_ctrl_t            in_ctrl  [num_ports],
   input  logic [num_ports-1:0] in_wr,
   output logic [num_ports-1:0] in_rdy,

   output pkt_data_t            out_data [num_ports],
   output pkt_ctrl_t            out_ctrl [num_ports],
   output logic [num_ports-1:0] out_wr,
   input  logic [num_ports-1:0] out_rdy,

   input  logic                 reg_req,
   input  logic                 reg_rd_wr_l,
   input  reg_addr_t            reg_addr,
   input  reg_data_t            reg_wr_data,
   output logic                 reg_ack,
   output reg_data_t            reg_rd_data
);

   // --------------------------------------------------
   // Pipeline links and ring hops
   // --------------------------------------------------
   pkt_bus_if  arb_to_lut ();
   pkt_bus_if  lut_to_oq ();

   reg_ring_if ring_to_arb ();
   reg_ring_if ring_to_lut ();
   reg_ring_if ring_to_oq ();
   reg_ring_if ring_to_mst ();

   udp_reg_master i_reg_master (
      .clk         (clk),
      .reset       (reset),
      .reg_req     (reg_req),
      .reg_rd_wr_l (reg_rd_wr_l),
      .reg_addr    (reg_addr),
      .reg_wr_data (reg_wr_data),
      .reg_ack     (reg_ack),
      .reg_rd_data (reg_rd_data),
      .ring_out    (ring_to_arb.up),
      .ring_in     (ring_to_mst.down)
   );

   input_arbiter i_input_arbiter (
      .clk     (clk),
      .reset   (reset),
      .in_data (in_data),
      .in_ctrl (in_ctrl),
      .in_wr   (in_wr),
      .in_rdy  (in_rdy),
      .out     (arb_to_lut.src),
      .reg_in  (ring_to_arb.down),
      .reg_out (ring_to_lut.up)
   );

   output_port_lookup i_output_port_lookup (
      .clk     (clk),
      .reset   (reset),
      .in      (arb_to_lut.dst),
      .out     (lut_to_oq.src),
      .reg_in  (ring_to_lut.down),
      .reg_out (ring_to_oq.up)
   );

   // Last ring hop closes back to the master
   output_queues i_output_queues (
      .clk      (clk),
      .reset    (reset),
      .in       (lut_to_oq.dst),
      .out_data (out_data),
      .out_ctrl (out_ctrl),
      .out_wr   (out_wr),
      .out_rdy  (out_rdy),
      .reg_in   (ring_to_oq.down),
      .reg_out  (ring_to_mst.up)
   );

endmodule

`default_nettype wire

//--- dv/tb_user_data_path.sv
// User data path testbench
`timescale 1ns/1ps
`default_nettype none

module tb_user_data_path
   import pkt_pkg::*, reg_pkg::*;
;

   localparam pkt_ctrl_t last_ctrl    = 8'h01;
   localparam int        idle_timeout = 3000;
   localparam int        reg_timeout  = 50;

   logic                 clk;
   logic                 reset;
   pkt_data_t            in_data  [num_ports];
   pkt_ctrl_t            in_ctrl  [num_ports];
   logic [num_ports-1:0] in_wr;
   logic [num_ports-1:0] in_rdy;
   pkt_data_t            out_data [num_ports];
   pkt_ctrl_t            out_ctrl [num_ports];
   logic [num_ports-1:0] out_wr;
   logic [num_ports-1:0] out_rdy;
   logic                 reg_req;
   logic                 reg_rd_wr_l;
   reg_addr_t            reg_addr;
   reg_data_t            reg_wr_data;
   logic                 reg_ack;
   reg_data_t            reg_rd_data;

   // Words waiting at each input
   pkt_data_t in_q_data [num_ports][$];
   pkt_ctrl_t in_q_ctrl [num_ports][$];
   // Expected words, indexed by output port * num_ports + source port
   pkt_data_t exp_data [num_ports*num_ports][$];
   pkt_ctrl_t exp_ctrl [num_ports*num_ports][$];
   logic      mid_pkt [num_ports];
   port_idx_t cur_src [num_ports];
   int        seen_count [num_ports];
   int        num_checks;

   user_data_path i_dut (
      .clk         (clk),
      .reset       (reset),
      .in_data     (in_data),
      .in_ctrl     (in_ctrl),
      .in_wr       (in_wr),
      .in_rdy      (in_rdy),
      .out_data    (out_data),
      .out_ctrl    (out_ctrl),
      .out_wr      (out_wr),
      .out_rdy     (out_rdy),
      .reg_req     (reg_req),
      .reg_rd_wr_l (reg_rd_wr_l),
      .reg_addr    (reg_addr),
      .reg_wr_data (reg_wr_data),
      .reg_ack     (reg_ack),
      .reg_rd_data (reg_rd_data)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // --------------------------------------------------
   // Failure reporting and compare tasks
   // --------------------------------------------------
   task automatic abort_run();
      $display("Simulation failed");
      $fatal(1, "Stopped at the first failure");
   endtask

   task automatic reject_line(input logic [7:0] kind);
      $display("Malformed vector line of kind %c", kind);
      abort_run();
   endtask

   task automatic check_word(input int port, input pkt_data_t got_data,
                             input pkt_data_t want_data, input pkt_ctrl_t got_ctrl,
                             input pkt_ctrl_t want_ctrl);
      num_checks++;
      if (got_data !== want_data || got_ctrl !== want_ctrl)
      begin
         $display("Error at %0t ns: port %0d word %h ctrl %h, expected %h ctrl %h",
                  $time, port, got_data, got_ctrl, want_data, want_ctrl);
         abort_run();
      end
   endtask

   task automatic check_reg(input string what, input reg_data_t got, input reg_data_t want);
      num_checks++;
      if (got !== want)
      begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, want);
         abort_run();
      end
   endtask

   // --------------------------------------------------
   // Packet queueing and drain
   // --------------------------------------------------
   task automatic queue_packet(input int port, input int words, input pkt_data_t first,
                               input port_mask_t mask);
      pkt_data_t word;
      pkt_ctrl_t ctrl;
      for (int k = 0; k < words; k++)
      begin
         word = first + pkt_data_t'(k);
         if (k == 0)
            ctrl = ctrl_module_hdr;
         else if (k == words - 1)
            ctrl = last_ctrl;
         else
            ctrl = ctrl_payload;
         in_q_data[port].push_back(word);
         in_q_ctrl[port].push_back(ctrl);
         // Header leaves with its source stamped and its route filled in
         if (k == 0)
         begin
            word[hdr_src_lsb +: $bits(port_idx_t)] = port_idx_t'(port);
            word[hdr_dst_lsb +: num_ports]         = mask;
         end
         for (int o = 0; o < num_ports; o++)
         begin
            if (mask[o])
            begin
               exp_data[o*num_ports + port].push_back(word);
               exp_ctrl[o*num_ports + port].push_back(ctrl);
            end
         end
      end
   endtask

   function automatic logic pipeline_empty();
      logic empty;
      empty = 1'b1;
      for (int p = 0; p < num_ports; p++)
         if (in_q_data[p].size() != 0 || mid_pkt[p])
            empty = 1'b0;
      for (int i = 0; i < num_ports*num_ports; i++)
         if (exp_data[i].size() != 0)
            empty = 1'b0;
      return empty;
   endfunction

   task automatic wait_idle();
      int cycles;
      cycles = 0;
      while (!pipeline_empty())
      begin
         cycles++;
         if (cycles > idle_timeout)
         begin
            $display("Packets did not drain from the data path by %0t ns", $time);
            abort_run();
         end
         @(posedge clk);
      end
   endtask

   // Core side of the req/ack register handshake
   task automatic reg_access(input logic rd_wr_l, input reg_addr_t addr,
                             input reg_data_t wr_data, output reg_data_t rd_data);
      int cycles;
      @(posedge clk);
      #1;
      reg_req     = 1'b1;
      reg_rd_wr_l = rd_wr_l;
      reg_addr    = addr;
      reg_wr_data = wr_data;
      cycles      = 0;
      @(negedge clk);
      while (!reg_ack)
      begin
         cycles++;
         if (cycles > reg_timeout)
         begin
            $display("No reg_ack for the access to address %h", addr);
            abort_run();
         end
         @(negedge clk);
      end
      rd_data = reg_rd_data;
      @(posedge clk);
      #1;
      reg_req = 1'b0;
      @(posedge clk);
   endtask

   // --------------------------------------------------
   // Input driver and random output back-pressure
   // --------------------------------------------------
   initial
   begin
      in_wr   = '0;
      out_rdy = '0;
      for (int p = 0; p < num_ports; p++)
      begin
         in_data[p] = '0;
         in_ctrl[p] = '0;
      end
      forever
      begin
         @(posedge clk);
         #1;
         for (int p = 0; p < num_ports; p++)
         begin
            out_rdy[p] = ($urandom_range(3) != 0);
            if (in_q_data[p].size() != 0 && in_rdy[p])
            begin
               in_data[p] = in_q_data[p].pop_front();
               in_ctrl[p] = in_q_ctrl[p].pop_front();
               in_wr[p]   = 1'b1;
            end
            else
               in_wr[p] = 1'b0;
         end
      end
   end

   // Output monitor, one scoreboard per output port
   initial
   begin
      pkt_data_t e_data;
      pkt_ctrl_t e_ctrl;
      int        idx;
      for (int p = 0; p < num_ports; p++)
      begin
         mid_pkt[p]    = 1'b0;
         cur_src[p]    = '0;
         seen_count[p] = 0;
      end
      forever
      begin
         @(negedge clk);
         for (int p = 0; p < num_ports; p++)
         begin
            if (out_wr[p] === 1'b1)
            begin
               if (!mid_pkt[p])
                  cur_src[p] = out_data[p][hdr_src_lsb +: $bits(port_idx_t)];
               idx = p*num_ports + int'(cur_src[p]);
               if (exp_data[idx].size() == 0)
               begin
                  $display("Unexpected word from port %0d on output port %0d at %0t ns",
                           cur_src[p], p, $time);
                  abort_run();
               end
               e_data = exp_data[idx].pop_front();
               e_ctrl = exp_ctrl[idx].pop_front();
               check_word(p, out_data[p], e_data, out_ctrl[p], e_ctrl);
               mid_pkt[p] = (e_ctrl != last_ctrl);
               if (e_ctrl == last_ctrl)
                  seen_count[p]++;
            end
         end
      end
   end

   // --------------------------------------------------
   // Vector file sequencer
   // --------------------------------------------------
   initial
   begin
      int                 fd;
      logic [7:0]         kind;
      logic [8*200-1:0]   line_buf;
      reg_addr_t          addr;
      reg_data_t          data;
      reg_data_t          rd_data;
      int                 port;
      int                 words;
      int                 count;
      pkt_data_t          first;
      port_mask_t         mask;
      void'($urandom(32'hf8b5));
      num_checks  = 0;
      reg_req     = 1'b0;
      reg_rd_wr_l = 1'b0;
      reg_addr    = '0;
      reg_wr_data = '0;
      reset       = 1'b1;
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;
      @(posedge clk);
      fd = $fopen("dv/user_data_path_vectors.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open the vector file");
         abort_run();
      end
      while ($fscanf(fd, " %c", kind) == 1)
      begin
         case (kind)
            "#":
               void'($fgets(line_buf, fd));
            "W":
            begin
               if ($fscanf(fd, " %h %h", addr, data) != 2)
                  reject_line(kind);
               wait_idle();
               reg_access(1'b0, addr, data, rd_data);
            end
            "R":
            begin
               if ($fscanf(fd, " %h %h", addr, data) != 2)
                  reject_line(kind);
               wait_idle();
               reg_access(1'b1, addr, '0, rd_data);
               check_reg("register read", rd_data, data);
            end
            "P":
            begin
               if ($fscanf(fd, " %d %d %h %h", port, words, first, mask) != 4)
                  reject_line(kind);
               if (port < 0 || port >= num_ports || words < 2)
                  reject_line(kind);
               queue_packet(port, words, first, mask);
            end
            "C":
            begin
               if ($fscanf(fd, " %d %d", port, count) != 2)
                  reject_line(kind);
               if (port < 0 || port >= num_ports)
                  reject_line(kind);
               wait_idle();
               addr = {block_oq, reg_offset_t'(port)};
               reg_access(1'b1, addr, '0, rd_data);
               check_reg("packet counter", rd_data, reg_data_t'(seen_count[port]));
               check_reg("packets seen", reg_data_t'(seen_count[port]), reg_data_t'(count));
            end
            default:
               reject_line(kind);
         endcase
      end
      $fclose(fd);
      wait_idle();
      if (num_checks > 0)
      begin
         $display("Simulation completed successfully");
         $finish;
      end
      else
      begin
         $display("The vector file produced no checks");
         abort_run();
      end
   end

endmodule

`default_nettype wire

//--- dv/user_data_path_vectors.txt
# W addr data : register write      R addr data : register read with expected data
# P port words first_data mask : packet      C port packets : output counter check
# Reset table routes port i to port i xor 1
R 010000 00000002
R 010001 00000001
R 010002 00000008
R 010003 00000004
# One packet per input on the default routes
P 0 4 0123456789abcdef 2
P 1 3 fedcba9876543210 1
P 2 5 00ff00ff00ff00ff 8
P 3 2 a5a5a5a5a5a5a5a5 4
C 0 1
C 1 1
C 2 1
C 3 1
# Blocks and offsets that no stage claims
R 030000 deadbeef
R 010004 deadbeef
W 030000 12345678
# New routes, port 0 to ports 0 2 3 and port 2 to ports 0 1
W 010000 0000000d
R 010000 0000000d
W 010002 00000003
R 010002 00000003
P 0 6 5555aaaa00000000 d
P 2 3 6666bbbb00030000 3
# All four inputs busy at once, long enough to fill a queue
P 0 20 1000000000000000 d
P 1 17 2000000000010000 1
P 2 9 3000000000020000 3
P 3 12 4000000000030000 4
P 0 3 5000000000000000 d
P 1 2 6000000000000000 1
# Counter block ignores writes
W 020000 00000099
R 010003 00000004
C 0 8
C 1 3
C 2 5
C 3 4

//--- vlog.f
source/pkt_pkg.sv
source/reg_pkg.sv
source/pkt_bus_if.sv
source/reg_ring_if.sv
source/input_arbiter.sv
source/output_port_lookup.sv
source/output_queues.sv
source/udp_reg_master.sv
source/user_data_path.sv
dv/tb_user_data_path.sv

//--- Makefile
TOP = tb_user_data_path

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir
